// File: dv/coherenceTb.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module coherenceTb;
	localparam int NumPorts = `COH_NUM_CACHES;
	localparam int MaxLatency = 12;
	// Requests issued by all tests together, used for the run limit.
	localparam int NumRequests = 2 + 4 + 8 + 3 + 4 + 200;
	localparam int CycleLimit = NumRequests * MaxLatency + 100;

	logic clock;
	logic rstN;
	coherencePkg::cpuReqT cpuReq [NumPorts];
	coherencePkg::cpuRespT cpuResp [NumPorts];

	logic [`COH_DATA_WIDTH-1:0] refMem [1 << `COH_ADDR_WIDTH];
	int errors;
	int errorsMark;
	int testsRun;
	int testsFailed;
	int cycles;
	integer seed;

	coherenceTop dut0 (
		.clock(clock),
		.rstN(rstN),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp)
	);

	initial begin
		clock = 1'b0;
	end

	always #2 clock = ~clock;

	// The reference memory takes a write when the writer's done pulse is seen.
	always @(posedge clock) begin
		if (!rstN) begin
			for (int a = 0; a < (1 << `COH_ADDR_WIDTH); a++) begin
				refMem[a] <= '0;
			end
		end else begin
			for (int p = 0; p < NumPorts; p++) begin
				if (cpuResp[p].done && cpuReq[p].write) begin
					refMem[cpuReq[p].addr] <= cpuReq[p].wrData;
				end
			end
		end
	end

	generate
		for (genvar p = 0; p < NumPorts; p++) begin : portCheck
			logic [`COH_DATA_WIDTH-1:0] expData;

			assign expData = refMem[cpuReq[p].addr];

			assert property (@(posedge clock) disable iff (!rstN)
				(cpuResp[p].done && !cpuReq[p].write) |-> cpuResp[p].rdData == expData)
			else begin
				errors++;
				$display("FAILED cpuResp[%0d].rdData expected %h actual %h", p,
					$sampled(expData), $sampled(cpuResp[p].rdData));
			end

			assert property (@(posedge clock) disable iff (!rstN)
				cpuResp[p].done |-> cpuReq[p].valid)
			else begin
				errors++;
				$display("Port %0d pulsed done while no request was valid", p);
			end

			assert property (@(posedge clock) disable iff (!rstN)
				cpuResp[p].done |=> !cpuResp[p].done)
			else begin
				errors++;
				$display("Port %0d held done high for more than one cycle", p);
			end
		end
	endgenerate

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Run stopped after %0d cycles before the tests finished", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// Holds the request until done is sampled high, then drops it a cycle later.
	task automatic issue(input int port, input logic write, input logic [7:0] addr,
			input logic [31:0] data);
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		cpuReq[port] = '{valid: 1'b1, write: write, addr: addr, wrData: data};
		while (!seen && waited < MaxLatency) begin
			@(posedge clock);
			#1;
			waited++;
			seen = cpuResp[port].done;
		end
		if (!seen) begin
			errors++;
			$display("Port %0d request to address %h got no done within %0d cycles",
				port, addr, MaxLatency);
		end else begin
			@(posedge clock);
			#1;
		end
		cpuReq[port] = '0;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors != errorsMark) begin
			testsFailed++;
			$display("%s: FAIL", name);
		end else begin
			$display("%s: PASS", name);
		end
		errorsMark = errors;
	endtask

	initial begin
		logic [31:0] rnd;
		errors = 0;
		errorsMark = 0;
		testsRun = 0;
		testsFailed = 0;
		cycles = 0;
		seed = 32'ha132_9c23;
		rstN = 1'b0;
		for (int p = 0; p < NumPorts; p++) begin
			cpuReq[p] = '0;
		end
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;

		repeat (4) @(posedge clock);
		#1;
		issue(1, 1'b0, 8'h7f, '0);
		issue(0, 1'b0, 8'h03, '0);
		finishTest("reset and idle");

		issue(0, 1'b1, 8'h10, 32'hcafe_0010);
		issue(1, 1'b0, 8'h10, '0);
		issue(1, 1'b1, 8'h10, 32'hbeef_0110);
		issue(0, 1'b0, 8'h10, '0);
		finishTest("owner supply and upgrade");

		for (int k = 0; k < 4; k++) begin
			issue(0, 1'b0, 8'h10, '0);
			issue(1, 1'b0, 8'h10, '0);
		end
		finishTest("shared reads");

		issue(0, 1'b1, 8'h21, 32'h1234_0021);
		issue(0, 1'b1, 8'h25, 32'h5678_0025);
		issue(0, 1'b0, 8'h21, '0);
		finishTest("victim write-back");

		fork
			issue(0, 1'b1, 8'h32, 32'h0a0a_0032);
			issue(1, 1'b0, 8'h43, '0);
		join
		fork
			issue(0, 1'b0, 8'h43, '0);
			issue(1, 1'b1, 8'h33, 32'h0b0b_0033);
		join
		finishTest("simultaneous requests");

		for (int k = 0; k < 200; k++) begin
			rnd = $random(seed);
			issue(int'(rnd[0]), rnd[1], {4'h0, rnd[5:2]}, $random(seed));
		end
		finishTest("random traffic");

		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule : coherenceTb

// File: hw/busArbiter.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module busArbiter (
	input logic clock,
	input logic rstN,
	input logic [`COH_NUM_CACHES-1:0] busRequest,
	output logic [`COH_NUM_CACHES-1:0] busGrant
);
	localparam int NumCaches = `COH_NUM_CACHES;
	localparam int PtrWidth = $clog2(NumCaches);

	logic [NumCaches-1:0] owner;
	logic [NumCaches-1:0] rrPick;
	logic [PtrWidth-1:0] lastPtr;
	logic [PtrWidth-1:0] grantPtr;

	// Scan downwards so the requester nearest after the last owner is written last and wins.
	always_comb begin
		int idx;
		rrPick = '0;
		for (int k = NumCaches; k >= 1; k--) begin
			idx = (int'(lastPtr) + k) % NumCaches;
			if (busRequest[idx]) begin
				rrPick = '0;
				rrPick[idx] = 1'b1;
			end
		end
	end

	// The current owner keeps the bus for as long as it keeps requesting.
	assign busGrant = (|(owner & busRequest)) ? owner : rrPick;

	always_comb begin
		grantPtr = lastPtr;
		for (int i = 0; i < NumCaches; i++) begin
			if (busGrant[i]) begin
				grantPtr = PtrWidth'(i);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			owner <= '0;
			lastPtr <= PtrWidth'(NumCaches - 1);
		end else begin
			owner <= busGrant;
			if (|busGrant) begin
				lastPtr <= grantPtr;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstN) $onehot0(busGrant))
		else $error("More than one cache holds the bus grant");

	assert property (@(posedge clock) disable iff (!rstN) (busGrant & ~busRequest) == '0)
		else $error("Bus granted to a cache that is not requesting");

endmodule : busArbiter

// File: hw/coherencePkg.sv
`include "coherence_defs.svh"

package coherencePkg;

	// MOESI line states. Invalid is zero so a cleared state array reads as empty.
	typedef enum logic [2:0] {
		Invalid   = 3'd0,
		Shared    = 3'd1,
		Exclusive = 3'd2,
		Owned     = 3'd3,
		Modified  = 3'd4
	} lineStateT;

	typedef enum logic [2:0] {
		BusIdle = 3'd0,
		BusRd   = 3'd1,
		BusRdX  = 3'd2,
		BusUpgr = 3'd3,
		BusWb   = 3'd4
	} busOpT;

	typedef struct packed {
		logic valid;
		logic write;
		logic [`COH_ADDR_WIDTH-1:0] addr;
		logic [`COH_DATA_WIDTH-1:0] wrData;
	} cpuReqT;

	typedef struct packed {
		logic done;
		logic [`COH_DATA_WIDTH-1:0] rdData;
	} cpuRespT;

	// The data field only carries a value for BusWb.
	typedef struct packed {
		busOpT op;
		logic [`COH_ADDR_WIDTH-1:0] addr;
		logic [`COH_DATA_WIDTH-1:0] data;
	} busCmdT;

	typedef struct packed {
		logic shared;
		logic owned;
		logic [`COH_DATA_WIDTH-1:0] data;
	} snoopRespT;

	typedef struct packed {
		logic done;
		logic shared;
		logic [`COH_DATA_WIDTH-1:0] data;
	} busRespT;

endpackage : coherencePkg

// File: hw/coherenceTop.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module coherenceTop (
	input logic clock,
	input logic rstN,
	input coherencePkg::cpuReqT cpuReq [`COH_NUM_CACHES],
	output coherencePkg::cpuRespT cpuResp [`COH_NUM_CACHES]
);
	genvar i;

	logic [`COH_NUM_CACHES-1:0] busRequest;
	logic [`COH_NUM_CACHES-1:0] busGrant;
	coherencePkg::busCmdT masterCmd [`COH_NUM_CACHES];
	coherencePkg::busRespT masterResp [`COH_NUM_CACHES];
	coherencePkg::busCmdT snoopCmd [`COH_NUM_CACHES];
	coherencePkg::snoopRespT snoopResp [`COH_NUM_CACHES];
	coherencePkg::busCmdT memCmd;
	logic [`COH_DATA_WIDTH-1:0] memRdData;

	busArbiter arbiter (
		.clock(clock),
		.rstN(rstN),
		.busRequest(busRequest),
		.busGrant(busGrant)
	);

	generate
		for (i = 0; i < `COH_NUM_CACHES; i++) begin : cacheGen
			coherentCache cache (
				.clock(clock),
				.rstN(rstN),
				.cpuReq(cpuReq[i]),
				.cpuResp(cpuResp[i]),
				.busRequest(busRequest[i]),
				.busGrant(busGrant[i]),
				.busCmd(masterCmd[i]),
				.busResp(masterResp[i]),
				.snoopCmd(snoopCmd[i]),
				.snoopResp(snoopResp[i])
			);
		end
	endgenerate

	snoopyBus snoopyBus (
		.busGrant(busGrant),
		.masterCmd(masterCmd),
		.masterResp(masterResp),
		.snoopCmd(snoopCmd),
		.snoopResp(snoopResp),
		.memCmd(memCmd),
		.memRdData(memRdData),
		.clock(clock),
		.rstN(rstN)
	);

	mainMemory memory (
		.clock(clock),
		.rstN(rstN),
		.memCmd(memCmd),
		.memRdData(memRdData)
	);

endmodule : coherenceTop

// File: hw/coherence_defs.svh
`ifndef COHERENCE_DEFS_SVH
`define COHERENCE_DEFS_SVH

// Word address width. Every address names one 32-bit word.
`define COH_ADDR_WIDTH 8

`define COH_DATA_WIDTH 32

// Two index bits give four lines per cache. The tag is the rest of the address.
`define COH_INDEX_WIDTH 2

// Number of processor ports, each with its own cache.
`define COH_NUM_CACHES 2

`endif

// File: hw/coherentCache.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module coherentCache (
	input logic clock,
	input logic rstN,
	input coherencePkg::cpuReqT cpuReq,
	output coherencePkg::cpuRespT cpuResp,
	output logic busRequest,
	input logic busGrant,
	output coherencePkg::busCmdT busCmd,
	input coherencePkg::busRespT busResp,
	input coherencePkg::busCmdT snoopCmd,
	output coherencePkg::snoopRespT snoopResp
);
	localparam int Lines = 1 << `COH_INDEX_WIDTH;
	localparam int TagWidth = `COH_ADDR_WIDTH - `COH_INDEX_WIDTH;

	typedef enum logic [1:0] {
		Idle,
		WriteBack,
		Fill,
		Upgrade
	} ctrlStateT;

	ctrlStateT ctrlState;

	logic [TagWidth-1:0] tagArr [Lines];
	coherencePkg::lineStateT stateArr [Lines];
	logic [`COH_DATA_WIDTH-1:0] dataArr [Lines];

	logic [`COH_INDEX_WIDTH-1:0] reqIndex;
	logic [`COH_INDEX_WIDTH-1:0] snoopIndex;
	logic [TagWidth-1:0] reqTag;
	logic [TagWidth-1:0] snoopTag;
	coherencePkg::lineStateT reqState;
	coherencePkg::lineStateT snoopState;
	logic reqHit;
	logic victimDirty;
	logic snoopHit;
	logic snoopConflict;

	assign reqIndex = cpuReq.addr[`COH_INDEX_WIDTH-1:0];
	assign reqTag = cpuReq.addr[`COH_ADDR_WIDTH-1:`COH_INDEX_WIDTH];
	assign reqState = stateArr[reqIndex];
	assign reqHit = reqState != coherencePkg::Invalid && tagArr[reqIndex] == reqTag;

	// On a miss the slot holds the victim; it must go back to memory if this cache owns it.
	assign victimDirty = reqState == coherencePkg::Modified || reqState == coherencePkg::Owned;

	assign snoopIndex = snoopCmd.addr[`COH_INDEX_WIDTH-1:0];
	assign snoopTag = snoopCmd.addr[`COH_ADDR_WIDTH-1:`COH_INDEX_WIDTH];
	assign snoopState = stateArr[snoopIndex];
	assign snoopHit = snoopCmd.op != coherencePkg::BusIdle
		&& snoopState != coherencePkg::Invalid
		&& tagArr[snoopIndex] == snoopTag;

	// A bus command on the same slot holds off the processor for one cycle,
	// so the two sides never update one line together.
	assign snoopConflict = snoopCmd.op != coherencePkg::BusIdle && snoopIndex == reqIndex;

	// A victim taken away by a snoop while waiting needs no write-back.
	assign busRequest = (ctrlState == WriteBack) ? victimDirty : (ctrlState != Idle);

	always_comb begin
		busCmd = '0;
		if (busGrant) begin
			unique case (ctrlState)
				WriteBack: begin
					busCmd.op = coherencePkg::BusWb;
					busCmd.addr = {tagArr[reqIndex], reqIndex};
					busCmd.data = dataArr[reqIndex];
				end
				Fill: begin
					busCmd.op = cpuReq.write ? coherencePkg::BusRdX : coherencePkg::BusRd;
					busCmd.addr = cpuReq.addr;
				end
				Upgrade: begin
					// The shared copy may have been invalidated while waiting for the bus.
					busCmd.op = reqHit ? coherencePkg::BusUpgr : coherencePkg::BusRdX;
					busCmd.addr = cpuReq.addr;
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		snoopResp = '0;
		if (snoopHit) begin
			snoopResp.shared = 1'b1;
			if ((snoopCmd.op == coherencePkg::BusRd || snoopCmd.op == coherencePkg::BusRdX)
					&& (snoopState == coherencePkg::Modified
					|| snoopState == coherencePkg::Owned)) begin
				snoopResp.owned = 1'b1;
				snoopResp.data = dataArr[snoopIndex];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			ctrlState <= Idle;
			cpuResp.done <= 1'b0;
			for (int i = 0; i < Lines; i++) begin
				stateArr[i] <= coherencePkg::Invalid;
			end
		end else begin
			cpuResp.done <= 1'b0;

			if (snoopHit) begin
				case (snoopCmd.op)
					coherencePkg::BusRd: begin
						if (snoopState == coherencePkg::Modified) begin
							stateArr[snoopIndex] <= coherencePkg::Owned;
						end else if (snoopState == coherencePkg::Exclusive) begin
							stateArr[snoopIndex] <= coherencePkg::Shared;
						end
					end
					coherencePkg::BusRdX, coherencePkg::BusUpgr: begin
						stateArr[snoopIndex] <= coherencePkg::Invalid;
					end
					default: begin
					end
				endcase
			end

			unique case (ctrlState)
				Idle: begin
					// The done cycle is skipped because the request seen then is the one just served.
					if (cpuReq.valid && !cpuResp.done && !snoopConflict) begin
						if (reqHit && !cpuReq.write) begin
							cpuResp.done <= 1'b1;
							cpuResp.rdData <= dataArr[reqIndex];
						end else if (reqHit && (reqState == coherencePkg::Modified
								|| reqState == coherencePkg::Exclusive)) begin
							dataArr[reqIndex] <= cpuReq.wrData;
							stateArr[reqIndex] <= coherencePkg::Modified;
							cpuResp.done <= 1'b1;
						end else if (reqHit) begin
							ctrlState <= Upgrade;
						end else if (victimDirty) begin
							ctrlState <= WriteBack;
						end else begin
							ctrlState <= Fill;
						end
					end
				end
				WriteBack: begin
					if (!victimDirty) begin
						ctrlState <= Fill;
					end else if (busGrant && busResp.done) begin
						stateArr[reqIndex] <= coherencePkg::Invalid;
						ctrlState <= Fill;
					end
				end
				Fill, Upgrade: begin
					if (busGrant && busResp.done) begin
						tagArr[reqIndex] <= reqTag;
						cpuResp.done <= 1'b1;
						ctrlState <= Idle;
						if (cpuReq.write) begin
							dataArr[reqIndex] <= cpuReq.wrData;
							stateArr[reqIndex] <= coherencePkg::Modified;
						end else begin
							dataArr[reqIndex] <= busResp.data;
							cpuResp.rdData <= busResp.data;
							stateArr[reqIndex] <= busResp.shared ? coherencePkg::Shared
								: coherencePkg::Exclusive;
						end
					end
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (!rstN) cpuResp.done |-> cpuReq.valid)
		else $error("Done pulsed with no valid processor request");

endmodule : coherentCache

// File: hw/mainMemory.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module mainMemory (
	input logic clock,
	input logic rstN,
	input coherencePkg::busCmdT memCmd,
	output logic [`COH_DATA_WIDTH-1:0] memRdData
);
	localparam int Words = 1 << `COH_ADDR_WIDTH;

	logic [`COH_DATA_WIDTH-1:0] mem [Words];

	// Read data appears one cycle after the command, in the bus's wait cycle.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			memRdData <= '0;
			for (int i = 0; i < Words; i++) begin
				mem[i] <= '0;
			end
		end else begin
			case (memCmd.op)
				coherencePkg::BusRd, coherencePkg::BusRdX: begin
					memRdData <= mem[memCmd.addr];
				end
				coherencePkg::BusWb: begin
					mem[memCmd.addr] <= memCmd.data;
				end
				default: begin
				end
			endcase
		end
	end

endmodule : mainMemory

// File: hw/snoopyBus.sv
`timescale 1ns/1ps
`include "coherence_defs.svh"

module snoopyBus (
	input logic [`COH_NUM_CACHES-1:0] busGrant,
	input coherencePkg::busCmdT masterCmd [`COH_NUM_CACHES],
	output coherencePkg::busRespT masterResp [`COH_NUM_CACHES],
	output coherencePkg::busCmdT snoopCmd [`COH_NUM_CACHES],
	input coherencePkg::snoopRespT snoopResp [`COH_NUM_CACHES],
	output coherencePkg::busCmdT memCmd,
	input logic [`COH_DATA_WIDTH-1:0] memRdData,
	input logic clock,
	input logic rstN
);
	localparam int NumCaches = `COH_NUM_CACHES;

	coherencePkg::busCmdT grantedCmd;
	coherencePkg::busRespT resp;
	logic [NumCaches-1:0] ownedBits;
	logic [NumCaches-1:0] sharedBits;
	logic [`COH_DATA_WIDTH-1:0] ownerData;
	logic anyOwned;
	logic anyShared;
	logic needMem;
	logic memWait;
	logic sharedHold;

	always_comb begin
		grantedCmd = '0;
		ownerData = '0;
		for (int i = 0; i < NumCaches; i++) begin
			if (busGrant[i]) begin
				grantedCmd = masterCmd[i];
			end
			ownedBits[i] = snoopResp[i].owned;
			sharedBits[i] = snoopResp[i].shared;
			if (snoopResp[i].owned) begin
				ownerData = snoopResp[i].data;
			end
		end
	end

	assign anyOwned = |ownedBits;
	assign anyShared = |sharedBits;

	// Reads go to memory only when no cache owns the line.
	always_comb begin
		case (grantedCmd.op)
			coherencePkg::BusRd, coherencePkg::BusRdX: needMem = !anyOwned;
			coherencePkg::BusWb: needMem = 1'b1;
			default: needMem = 1'b0;
		endcase
	end

	assign memCmd = (needMem && !memWait) ? grantedCmd : '0;

	// In the second cycle of a memory access the snoop has already been served.
	always_comb begin
		resp = '0;
		if (memWait) begin
			resp.done = 1'b1;
			resp.shared = sharedHold;
			resp.data = memRdData;
		end else if (grantedCmd.op != coherencePkg::BusIdle && !needMem) begin
			resp.done = 1'b1;
			resp.shared = anyShared;
			resp.data = ownerData;
		end
	end

	always_comb begin
		for (int i = 0; i < NumCaches; i++) begin
			masterResp[i] = busGrant[i] ? resp : '0;
			snoopCmd[i] = (busGrant[i] || memWait) ? '0 : grantedCmd;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			memWait <= 1'b0;
		end else begin
			memWait <= needMem && !memWait;
		end
	end

	always_ff @(posedge clock) begin
		sharedHold <= anyShared;
	end

	assert property (@(posedge clock) disable iff (!rstN) $onehot0(ownedBits))
		else $error("Two caches claim ownership of the same line");

endmodule : snoopyBus

// File: verilog.f
+incdir+hw
hw/coherencePkg.sv
hw/busArbiter.sv
hw/coherentCache.sv
hw/snoopyBus.sv
hw/mainMemory.sv
hw/coherenceTop.sv
dv/coherenceTb.sv
